// ==== verilog/loadPkg.sv ====
package loadPkg;

    localparam int NumRegs = 64;
    localparam int NumFetchIds = 16;
    localparam int NumXus = 8;

    typedef logic [6:0] SqN;
    typedef logic [3:0] FetchId;

    typedef enum logic [2:0] {
        FU_INT,
        FU_LSU,
        FU_ST,
        FU_MUL,
        FU_DIV,
        FU_FPU,
        FU_FDIV,
        FU_FMUL
    } FuncUnit;

    typedef struct packed {
        logic predicted;
        logic taken;
        logic isJump;
    } BranchInfo;

    // Operand tag, special bit set means inline constant
    typedef struct packed {
        logic special;
        logic [5:0] idx;
    } RegTag;

    typedef struct packed {
        logic special;
        logic signed [5:0] value;
    } ConstTag;

    typedef union packed {
        RegTag regView;
        ConstTag constView;
    } OperandTag;

    typedef struct packed {
        OperandTag tagA;
        OperandTag tagB;
        logic [5:0] tagDst;
        logic immB;
        logic [31:0] imm;
        SqN sqN;
        FetchId fetchId;
        logic [1:0] fetchOffs;
        logic compressed;
        FuncUnit fu;
    } IssueUop;

    // Base pc holds PC[31:1] of the fetch block
    typedef struct packed {
        logic [30:0] pc;
        logic [1:0] branchPos;
        BranchInfo bpi;
    } PcEntry;

    typedef struct packed {
        logic [31:0] srcA;
        logic [31:0] srcB;
        logic [31:0] imm;
        logic [31:0] pc;
        SqN sqN;
        logic [5:0] tagDst;
        BranchInfo bpi;
        logic compressed;
        FuncUnit fu;
        logic [NumXus-1:0] enableXu;
    } ExecUop;

    typedef struct packed {
        logic valid;
        logic [5:0] tagDst;
        logic [31:0] result;
    } WbResult;

    // True when sqN is younger than the flush point
    function automatic logic isFlushed(SqN sqN, logic flush, SqN flushSqN);
        return flush && ($signed(sqN - flushSqN) > 0);
    endfunction

endpackage

// ==== verilog/issueReceiver.sv ====
module issueReceiver (
    input  logic clk,
    input  logic rst,
    input  logic issueReq,
    input  loadPkg::IssueUop issueUop,
    output logic issueAck,
    input  logic take,
    input  logic flush,
    input  loadPkg::SqN flushSqN,
    output logic heldValid,
    output loadPkg::IssueUop heldUop
);

    logic accept;
    logic heldFlushed;
    logic inFlushed;

    // New request only after the previous ack has dropped
    assign accept = !heldValid && issueReq && !issueAck;
    assign heldFlushed = loadPkg::isFlushed(heldUop.sqN, flush, flushSqN);
    assign inFlushed = loadPkg::isFlushed(issueUop.sqN, flush, flushSqN);

    always_ff @(posedge clk) begin
        if (rst) begin
            heldValid <= 1'b0;
            issueAck <= 1'b0;
        end else begin
            if (heldValid) begin
                // Taken by the fetch stage or dropped by a flush
                if (take || heldFlushed) begin
                    heldValid <= 1'b0;
                    issueAck <= 1'b1;
                end
            end else if (accept) begin
                // A uop flushed on arrival is acked without being held
                if (inFlushed) begin
                    issueAck <= 1'b1;
                end else begin
                    heldValid <= 1'b1;
                end
            end else if (issueAck && !issueReq) begin
                issueAck <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            heldUop <= issueUop;
        end
    end

endmodule

// ==== verilog/regFile.sv ====
module regFile (
    input  logic clk,
    input  logic rst,
    input  logic [5:0] readAddrA,
    input  logic [5:0] readAddrB,
    output logic [31:0] readDataA,
    output logic [31:0] readDataB,
    input  loadPkg::WbResult wb
);

    logic [31:0] regs [loadPkg::NumRegs];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < loadPkg::NumRegs; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (wb.valid && wb.tagDst != 6'd0) begin
            regs[wb.tagDst] <= wb.result;
        end
    end

    // x0 is hardwired
    always_comb begin
        readDataA = (readAddrA == 6'd0) ? 32'd0 : regs[readAddrA];
        readDataB = (readAddrB == 6'd0) ? 32'd0 : regs[readAddrB];
    end

endmodule

// ==== verilog/pcFile.sv ====
module pcFile (
    input  logic clk,
    input  loadPkg::FetchId readId,
    output loadPkg::PcEntry readEntry,
    input  logic pcWrite,
    input  loadPkg::FetchId pcWriteId,
    input  loadPkg::PcEntry pcWriteEntry
);

    // One entry per fetch block in flight
    loadPkg::PcEntry entries [loadPkg::NumFetchIds];

    always_ff @(posedge clk) begin
        if (pcWrite) begin
            entries[pcWriteId] <= pcWriteEntry;
        end
    end

    assign readEntry = entries[readId];

endmodule

// ==== verilog/operandLoad.sv ====
module operandLoad (
    input  logic clk,
    input  logic rst,
    input  logic heldValid,
    input  loadPkg::IssueUop heldUop,
    output logic take,
    output logic [5:0] readAddrA,
    output logic [5:0] readAddrB,
    input  logic [31:0] readDataA,
    input  logic [31:0] readDataB,
    output loadPkg::FetchId readId,
    input  loadPkg::PcEntry readEntry,
    input  loadPkg::WbResult wb,
    input  logic flush,
    input  loadPkg::SqN flushSqN,
    input  logic busy,
    output logic outValid,
    output loadPkg::ExecUop outUop
);

    logic loaded;
    logic outFlushed;
    loadPkg::ExecUop nextUop;

    // Constant, then same-cycle writeback, then register file
    function automatic logic [31:0] pickOperand(
        loadPkg::OperandTag tag,
        logic [31:0] rfData,
        loadPkg::WbResult wbIn
    );
        logic [31:0] value;
        if (tag.constView.special) begin
            value = {{26{tag.constView.value[5]}}, tag.constView.value};
        end else if (wbIn.valid && wbIn.tagDst != 6'd0 && wbIn.tagDst == tag.regView.idx) begin
            value = wbIn.result;
        end else begin
            value = rfData;
        end
        return value;
    endfunction

    assign readAddrA = heldUop.tagA.regView.idx;
    assign readAddrB = heldUop.tagB.regView.idx;
    assign readId = heldUop.fetchId;

    // Flushed held uops are dropped by the receiver, never taken
    assign take = heldValid && !busy && !loadPkg::isFlushed(heldUop.sqN, flush, flushSqN);

    assign outFlushed = loadPkg::isFlushed(outUop.sqN, flush, flushSqN);
    assign outValid = loaded && !outFlushed;

    always_comb begin
        nextUop.srcA = pickOperand(heldUop.tagA, readDataA, wb);
        if (heldUop.immB) begin
            nextUop.srcB = heldUop.imm;
        end else begin
            nextUop.srcB = pickOperand(heldUop.tagB, readDataB, wb);
        end
        nextUop.imm = heldUop.imm;

        // Halfword offset into the block, back up to the start if 32-bit
        nextUop.pc = {readEntry.pc[30:2], heldUop.fetchOffs, 1'b0}
            - (heldUop.compressed ? 32'd0 : 32'd2);

        nextUop.sqN = heldUop.sqN;
        nextUop.tagDst = heldUop.tagDst;

        // Prediction belongs only to the branch slot
        if (heldUop.fetchOffs == readEntry.branchPos) begin
            nextUop.bpi = readEntry.bpi;
        end else begin
            nextUop.bpi = '0;
        end

        nextUop.compressed = heldUop.compressed;
        nextUop.fu = heldUop.fu;
        nextUop.enableXu = '0;
        nextUop.enableXu[heldUop.fu] = 1'b1;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            loaded <= 1'b0;
        end else if (take) begin
            loaded <= 1'b1;
        end else if (!busy || outFlushed) begin
            // Handed to the sender, or killed while stalled
            loaded <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            outUop <= nextUop;
        end
    end

endmodule

// ==== verilog/dispatchSender.sv ====
module dispatchSender (
    input  logic clk,
    input  logic rst,
    input  logic inValid,
    input  loadPkg::ExecUop inUop,
    output logic busy,
    output logic exReq,
    input  logic exAck,
    output loadPkg::ExecUop exUop
);

    logic capture;

    assign capture = !busy && inValid;

    // Four-phase master, busy covers the whole req/ack cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            exReq <= 1'b0;
        end else begin
            if (capture) begin
                busy <= 1'b1;
                exReq <= 1'b1;
            end else if (exReq && exAck) begin
                exReq <= 1'b0;
            end else if (busy && !exReq && !exAck) begin
                // Ack has dropped, link is idle again
                busy <= 1'b0;
            end
        end
    end

    // Payload stays put until the transfer completes
    always_ff @(posedge clk) begin
        if (capture) begin
            exUop <= inUop;
        end
    end

endmodule

// ==== verilog/operandFetchTop.sv ====
module operandFetchTop (
    input  logic clk,
    input  logic rst,
    input  logic issueReq,
    input  loadPkg::IssueUop issueUop,
    output logic issueAck,
    input  loadPkg::WbResult wb,
    input  logic pcWrite,
    input  loadPkg::FetchId pcWriteId,
    input  loadPkg::PcEntry pcWriteEntry,
    input  logic flush,
    input  loadPkg::SqN flushSqN,
    output logic exReq,
    input  logic exAck,
    output loadPkg::ExecUop exUop
);

    logic heldValid;
    loadPkg::IssueUop heldUop;
    logic take;
    logic [5:0] readAddrA;
    logic [5:0] readAddrB;
    logic [31:0] readDataA;
    logic [31:0] readDataB;
    loadPkg::FetchId readId;
    loadPkg::PcEntry readEntry;
    logic busy;
    logic loadValid;
    loadPkg::ExecUop loadUop;

    issueReceiver issueReceiver_i (
        .clk       (clk),
        .rst       (rst),
        .issueReq  (issueReq),
        .issueUop  (issueUop),
        .issueAck  (issueAck),
        .take      (take),
        .flush     (flush),
        .flushSqN  (flushSqN),
        .heldValid (heldValid),
        .heldUop   (heldUop)
    );

    regFile regFile_i (
        .clk       (clk),
        .rst       (rst),
        .readAddrA (readAddrA),
        .readAddrB (readAddrB),
        .readDataA (readDataA),
        .readDataB (readDataB),
        .wb        (wb)
    );

    pcFile pcFile_i (
        .clk          (clk),
        .readId       (readId),
        .readEntry    (readEntry),
        .pcWrite      (pcWrite),
        .pcWriteId    (pcWriteId),
        .pcWriteEntry (pcWriteEntry)
    );

    operandLoad operandLoad_i (
        .clk       (clk),
        .rst       (rst),
        .heldValid (heldValid),
        .heldUop   (heldUop),
        .take      (take),
        .readAddrA (readAddrA),
        .readAddrB (readAddrB),
        .readDataA (readDataA),
        .readDataB (readDataB),
        .readId    (readId),
        .readEntry (readEntry),
        .wb        (wb),
        .flush     (flush),
        .flushSqN  (flushSqN),
        .busy      (busy),
        .outValid  (loadValid),
        .outUop    (loadUop)
    );

    dispatchSender dispatchSender_i (
        .clk     (clk),
        .rst     (rst),
        .inValid (loadValid),
        .inUop   (loadUop),
        .busy    (busy),
        .exReq   (exReq),
        .exAck   (exAck),
        .exUop   (exUop)
    );

endmodule

// ==== test/operandFetch_asserts.sv ====
module handshakeAsserts (
    input logic clk,
    input logic rst,
    input logic req,
    input logic ack,
    input logic owned,
    input logic [159:0] payload
);

    int failCount = 0;

    // Request holds until acknowledged
    reqHeld: assert property (@(posedge clk) disable iff (rst) req && !ack |=> req)
        else begin
            $error("req dropped before ack");
            failCount++;
        end

    // Ack holds until the request is withdrawn
    ackHeld: assert property (@(posedge clk) disable iff (rst) req && ack |=> ack)
        else begin
            $error("ack dropped while req was still high");
            failCount++;
        end

    // No new request before ack is back low
    reqAfterAck: assert property (@(posedge clk) disable iff (rst) !req && ack |=> !req)
        else begin
            $error("req rose while ack was still high");
            failCount++;
        end

    payloadStable: assert property (@(posedge clk) disable iff (rst)
        req |=> !req || $stable(payload))
        else begin
            $error("payload changed while req was high");
            failCount++;
        end

    resetClears: assert property (@(posedge clk) rst |=> !req && !ack && !owned)
        else begin
            $error("handshake outputs not low after reset");
            failCount++;
        end

endmodule

bind issueReceiver handshakeAsserts issueLinkAsserts_i (
    .clk     (clk),
    .rst     (rst),
    .req     (issueReq),
    .ack     (issueAck),
    .owned   (heldValid),
    .payload ({90'd0, issueUop})
);

bind dispatchSender handshakeAsserts exLinkAsserts_i (
    .clk     (clk),
    .rst     (rst),
    .req     (exReq),
    .ack     (exAck),
    .owned   (busy),
    .payload ({4'd0, exUop})
);

// ==== test/operandFetchTb.sv ====
module operandFetchTb;

    logic clk;
    logic rst;
    logic issueReq;
    loadPkg::IssueUop issueUop;
    logic issueAck;
    loadPkg::WbResult wb;
    logic pcWrite;
    loadPkg::FetchId pcWriteId;
    loadPkg::PcEntry pcWriteEntry;
    logic flush;
    loadPkg::SqN flushSqN;
    logic exReq;
    logic exAck;
    loadPkg::ExecUop exUop;

    // Pending issues, their forwarded writebacks, and what must come out
    loadPkg::IssueUop issueQueue[$];
    loadPkg::WbResult fwdQueue[$];
    loadPkg::ExecUop expQueue[$];
    string nameQueue[$];
    logic [31:0] field [18];

    logic driving;
    logic holdAck;
    logic finished;
    logic timedOut;
    logic [31:0] rngState;
    int checks;
    int mismatches;
    int failures;
    int assertFails;

    operandFetchTop operandFetchTop_i (
        .clk          (clk),
        .rst          (rst),
        .issueReq     (issueReq),
        .issueUop     (issueUop),
        .issueAck     (issueAck),
        .wb           (wb),
        .pcWrite      (pcWrite),
        .pcWriteId    (pcWriteId),
        .pcWriteEntry (pcWriteEntry),
        .flush        (flush),
        .flushSqN     (flushSqN),
        .exReq        (exReq),
        .exAck        (exAck),
        .exUop        (exUop)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] state);
        logic [31:0] s;
        s = state;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // One clock of a bounded wait
    task automatic stepOrGiveUp(input string what, inout int count);
        @(posedge clk);
        count++;
        assert (count < 500) else begin
            $display("ERROR: timed out waiting for %s", what);
            failures++;
            timedOut = 1'b1;
        end
    endtask

    task automatic checkValue(input string test, input string name,
                              input logic [31:0] expected, input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            $display("MISMATCH %s %s expected %h actual %h", test, name, expected, actual);
            mismatches++;
        end
    endtask

    task automatic checkParsed(input int count, input int want, input string line);
        assert (count == want) else begin
            $display("ERROR: malformed trace line %s", line);
            failures++;
        end
    endtask

    task automatic drain();
        int n;
        n = 0;
        while ((issueQueue.size() != 0 || driving || expQueue.size() != 0 || exReq || exAck)
               && !timedOut) begin
            stepOrGiveUp("the pipeline to drain", n);
        end
        // Sender frees itself one cycle after ack drops
        repeat (2) @(posedge clk);
    endtask

    task automatic queueIssue(input string name);
        loadPkg::IssueUop uop;
        loadPkg::WbResult fwd;
        loadPkg::ExecUop expected;
        uop.tagA = field[0][6:0];
        uop.tagB = field[1][6:0];
        uop.tagDst = field[2][5:0];
        uop.immB = field[3][0];
        uop.imm = field[4];
        uop.sqN = field[5][6:0];
        uop.fetchId = field[6][3:0];
        uop.fetchOffs = field[7][1:0];
        uop.compressed = field[8][0];
        uop.fu = loadPkg::FuncUnit'(field[9][2:0]);
        fwd.valid = field[10][0];
        fwd.tagDst = field[11][5:0];
        fwd.result = field[12];
        expected.srcA = field[13];
        expected.srcB = field[14];
        expected.imm = field[4];
        expected.pc = field[15];
        expected.sqN = uop.sqN;
        expected.tagDst = uop.tagDst;
        expected.bpi = field[16][2:0];
        expected.compressed = uop.compressed;
        expected.fu = uop.fu;
        // FU_INT on bit 0 up to FU_FMUL on bit 7
        expected.enableXu = 8'b1 << field[9][2:0];
        // Forwarding needs an empty pipe so take follows req by one cycle
        if (fwd.valid) begin
            drain();
        end
        issueQueue.push_back(uop);
        fwdQueue.push_back(fwd);
        if (field[17][0]) begin
            expQueue.push_back(expected);
            nameQueue.push_back(name);
        end
    endtask

    task automatic pulseFlush();
        int n;
        n = 0;
        // Oldest uop on the output link, the next one waiting at the input
        while ((issueQueue.size() != 0 || !issueReq || !exReq) && !timedOut) begin
            stepOrGiveUp("uops to settle before the flush", n);
        end
        repeat (3) @(posedge clk);
        flush <= 1'b1;
        flushSqN <= field[0][6:0];
        @(posedge clk);
        flush <= 1'b0;
    endtask

    task automatic runTrace();
        int fd;
        int count;
        string line;
        string name;
        fd = $fopen("test/operandFetchTrace.txt", "r");
        assert (fd != 0) else begin
            $display("ERROR: could not open the trace file");
            failures++;
        end
        if (fd == 0) begin
            return;
        end
        while (!$feof(fd) && !timedOut) begin
            line = "";
            count = $fgets(line, fd);
            if (count == 0 || line.len() < 2 || line[0] == "#") begin
                continue;
            end
            case (line[0])
                "R": begin
                    count = $sscanf(line, "R %h %h", field[0], field[1]);
                    checkParsed(count, 2, line);
                    drain();
                    wb.valid <= 1'b1;
                    wb.tagDst <= field[0][5:0];
                    wb.result <= field[1];
                    @(posedge clk);
                    wb.valid <= 1'b0;
                end
                "P": begin
                    count = $sscanf(line, "P %h %h %h %h", field[0], field[1], field[2],
                                    field[3]);
                    checkParsed(count, 4, line);
                    drain();
                    pcWrite <= 1'b1;
                    pcWriteId <= field[0][3:0];
                    pcWriteEntry <= {field[1][30:0], field[2][1:0], field[3][2:0]};
                    @(posedge clk);
                    pcWrite <= 1'b0;
                end
                "I": begin
                    count = $sscanf(line,
                        "I %s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        name, field[0], field[1], field[2], field[3], field[4], field[5],
                        field[6], field[7], field[8], field[9], field[10], field[11],
                        field[12], field[13], field[14], field[15], field[16], field[17]);
                    checkParsed(count, 19, line);
                    queueIssue(name);
                end
                "H": begin
                    drain();
                    holdAck <= 1'b1;
                end
                "G": begin
                    holdAck <= 1'b0;
                end
                "F": begin
                    count = $sscanf(line, "F %h", field[0]);
                    checkParsed(count, 1, line);
                    pulseFlush();
                end
                default: begin
                    checkParsed(0, 1, line);
                end
            endcase
        end
        $fclose(fd);
    endtask

    task automatic checkDelivered();
        loadPkg::ExecUop expected;
        string name;
        assert (expQueue.size() > 0) else begin
            $display("ERROR: uop with sqN %h was delivered but none was expected", exUop.sqN);
            failures++;
        end
        if (expQueue.size() > 0) begin
            expected = expQueue.pop_front();
            name = nameQueue.pop_front();
            checkValue(name, "sqN", 32'(expected.sqN), 32'(exUop.sqN));
            checkValue(name, "srcA", expected.srcA, exUop.srcA);
            checkValue(name, "srcB", expected.srcB, exUop.srcB);
            checkValue(name, "imm", expected.imm, exUop.imm);
            checkValue(name, "pc", expected.pc, exUop.pc);
            checkValue(name, "tagDst", 32'(expected.tagDst), 32'(exUop.tagDst));
            checkValue(name, "bpi", 32'(expected.bpi), 32'(exUop.bpi));
            checkValue(name, "compressed", 32'(expected.compressed), 32'(exUop.compressed));
            checkValue(name, "fu", 32'(expected.fu), 32'(exUop.fu));
            checkValue(name, "enableXu", 32'(expected.enableXu), 32'(exUop.enableXu));
        end
    endtask

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    // Input link master
    initial begin : issueDriver
        loadPkg::IssueUop uop;
        loadPkg::WbResult fwd;
        int n;
        while (!finished && !timedOut) begin
            @(posedge clk);
            if (issueQueue.size() > 0 && !rst) begin
                uop = issueQueue.pop_front();
                fwd = fwdQueue.pop_front();
                driving = 1'b1;
                n = 0;
                while (issueAck && !timedOut) begin
                    stepOrGiveUp("issueAck to drop", n);
                end
                issueUop <= uop;
                issueReq <= 1'b1;
                if (fwd.valid) begin
                    // Writeback lands in the cycle the uop is taken
                    @(posedge clk);
                    wb <= fwd;
                    @(posedge clk);
                    wb.valid <= 1'b0;
                end
                n = 0;
                while (!issueAck && !timedOut) begin
                    stepOrGiveUp("issueAck", n);
                end
                issueReq <= 1'b0;
                driving = 1'b0;
            end
        end
    end

    // Output link slave with random ack delay
    initial begin : execResponder
        int n;
        int delay;
        while (!finished && !timedOut) begin
            @(posedge clk);
            if (exReq && !exAck && !holdAck) begin
                rngState = xorshift(rngState);
                delay = int'(rngState % 4);
                repeat (delay) @(posedge clk);
                checkDelivered();
                exAck <= 1'b1;
                n = 0;
                while (exReq && !timedOut) begin
                    stepOrGiveUp("exReq to drop", n);
                end
                exAck <= 1'b0;
            end
        end
    end

    initial begin
        rst = 1'b1;
        issueReq = 1'b0;
        issueUop = '0;
        wb = '0;
        pcWrite = 1'b0;
        pcWriteId = '0;
        pcWriteEntry = '0;
        flush = 1'b0;
        flushSqN = '0;
        exAck = 1'b0;
        driving = 1'b0;
        holdAck = 1'b0;
        finished = 1'b0;
        timedOut = 1'b0;
        rngState = 32'h402c_b2b4;
        checks = 0;
        mismatches = 0;
        failures = 0;
        assertFails = 0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        runTrace();
        drain();
        assert (checks > 0) else begin
            $display("ERROR: no uop reached the output link");
            failures++;
        end
        finished = 1'b1;
        @(posedge clk);
        assertFails = operandFetchTop_i.issueReceiver_i.issueLinkAsserts_i.failCount
            + operandFetchTop_i.dispatchSender_i.exLinkAsserts_i.failCount;
        $display("checks %0d, mismatches %0d, other errors %0d, assertion failures %0d",
                 checks, mismatches, failures, assertFails);
        if (mismatches == 0 && failures == 0 && assertFails == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== test/operandFetchTrace.txt ====
# R reg value | P id pcBase31 branchPos bpi | H hold acks | G release acks | F flushSqN
# I name tagA tagB tagDst immB imm sqN fetchId offs compr fu fwd fwdTag fwdVal expA expB expPc expBpi show
R 05 11111111
R 06 22222222
R 21 cafef00d
R 00 deadbeef
P 3 00000800 2 5
P 5 40000020 1 3
I regs 05 06 07 0 00000000 01 3 0 1 0 0 00 00000000 11111111 22222222 00001000 0 1
I zero 00 21 08 0 00000000 02 3 2 0 3 0 00 00000000 00000000 cafef00d 00001002 5 1
I constNeg 7d 00 09 1 00000abc 03 5 1 1 1 0 00 00000000 fffffffd 00000abc 80000042 3 1
I constPos 5f 60 0a 0 12345678 04 5 3 0 7 0 00 00000000 0000001f ffffffe0 80000044 0 1
I fwdA 05 06 0b 0 00000000 05 3 1 1 2 1 05 55aa55aa 55aa55aa 22222222 00001002 0 1
I fwdB 06 05 0c 0 00000000 06 3 3 0 4 1 06 0f0f0f0f 0f0f0f0f 55aa55aa 00001004 0 1
H
I onLink 05 06 0d 0 00000000 20 3 2 1 5 0 00 00000000 55aa55aa 0f0f0f0f 00001004 5 1
I flushYoung 05 06 0e 0 00000000 21 3 2 1 5 0 00 00000000 55aa55aa 0f0f0f0f 00001004 5 0
F 1f
G
H
I keepOld 21 05 0f 0 00000000 22 5 1 0 6 0 00 00000000 cafef00d 55aa55aa 80000040 3 1
I keepEqual 06 21 10 1 00000077 23 5 0 1 3 0 00 00000000 0f0f0f0f 00000077 80000040 0 1
F 23
G
I burst0 05 06 11 0 00000000 24 3 0 1 0 0 00 00000000 55aa55aa 0f0f0f0f 00001000 0 1
I burst1 21 7e 12 0 00000000 25 3 1 0 1 0 00 00000000 cafef00d fffffffe 00001000 0 1
I burst2 60 05 13 1 80000001 26 5 2 1 2 0 00 00000000 ffffffe0 80000001 80000044 0 1
I burst3 00 06 14 0 00000000 27 5 3 1 7 0 00 00000000 00000000 0f0f0f0f 80000046 0 1

// ==== operandFetchTop.f ====
verilog/loadPkg.sv
verilog/issueReceiver.sv
verilog/regFile.sv
verilog/pcFile.sv
verilog/operandLoad.sv
verilog/dispatchSender.sv
verilog/operandFetchTop.sv
test/operandFetch_asserts.sv
test/operandFetchTb.sv

// ==== Bender.yml ====
package:
  name: operandFetch

sources:
  - verilog/loadPkg.sv
  - verilog/issueReceiver.sv
  - verilog/regFile.sv
  - verilog/pcFile.sv
  - verilog/operandLoad.sv
  - verilog/dispatchSender.sv
  - verilog/operandFetchTop.sv
  - target: test
    files:
      - test/operandFetch_asserts.sv
      - test/operandFetchTb.sv
